//--- vlog.f
src/core_types_pkg.sv
src/alu.sv
src/alu_reg_pipeline.sv
src/prf_banks.sv
src/alu_lane_top.sv
test/alu_lane_sva.sv
test/tb_alu_lane.sv

//--- test/tb_alu_lane.sv
// random testbench for alu_lane_top, checked against a register file and ALU model
// registers 0 to 31 are preloaded and then only read, destinations are 32 to 47,
// random external writes go to 48 to 63
// at most one operand per operation is forwarded, from the external write port
`timescale 1ns/1ps
`default_nettype none

module tb_alu_lane;
    import core_types_pkg::*;

    localparam int NUM_OPS    = 300;
    localparam int WAIT_LIMIT = 200;

    logic        CLK;
    logic        nRST;
    logic        issue_valid;
    issue_op_t   issue;
    logic        issue_ready;
    logic        WB_valid;
    wb_req_t     wb;
    logic        WB_ready;
    logic        ext_write_valid;
    ext_write_t  ext_write;
    logic        ext_read_valid;
    logic [5:0]  ext_read_PR;
    logic [31:0] ext_read_data;

    logic [31:0] model_regs [PR_COUNT];
    wb_req_t     exp_q [$];
    logic [31:0] lcg_state;
    int          checks;
    int          value_errors;
    int          other_errors;
    bit          timed_out;
    // forward write owed to the cycle after an acceptance
    bit          fwd_pending;
    logic [1:0]  fwd_bank;
    logic [31:0] fwd_data;

    alu_lane_top #(
        .READ_PORTS_PER_BANK (2)
    ) u_dut (
        .CLK             (CLK),
        .nRST            (nRST),
        .issue_valid     (issue_valid),
        .issue           (issue),
        .issue_ready     (issue_ready),
        .WB_valid        (WB_valid),
        .wb              (wb),
        .WB_ready        (WB_ready),
        .ext_write_valid (ext_write_valid),
        .ext_write       (ext_write),
        .ext_read_valid  (ext_read_valid),
        .ext_read_PR     (ext_read_PR),
        .ext_read_data   (ext_read_data)
    );

    bind alu_reg_pipeline alu_lane_sva u_sva (
        .CLK            (CLK),
        .nRST           (nRST),
        .issue_ready    (issue_ready),
        .WB_valid       (WB_valid),
        .wb             (wb),
        .WB_ready       (WB_ready),
        .A_reg_read_ack (A_reg_read_ack),
        .B_reg_read_ack (B_reg_read_ack),
        .valid_oc       (valid_oc),
        .op_oc          (op_oc),
        .A_saved_oc     (A_saved_oc),
        .B_saved_oc     (B_saved_oc)
    );

    always #10 CLK = ~CLK;

    // --------------------------------------------------
    // random numbers and reference ALU

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'((next_rand() >> 8) % n);
    endfunction

    function automatic logic [31:0] ref_alu(input logic [3:0] code, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (code)
            4'd0: return a + b;
            4'd1: return a - b;
            4'd2: return a << sh;
            4'd3: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4'd4: return (a < b) ? 32'd1 : 32'd0;
            4'd5: return a ^ b;
            4'd6: return a >> sh;
            4'd7: return $signed(a) >>> sh;
            4'd8: return a | b;
            4'd9: return a & b;
            default: return 32'h0;
        endcase
    endfunction

    // --------------------------------------------------
    // stimulus helpers

    task automatic drive_ext();
        int k;
        k = rand_below(4);
        if (fwd_pending) begin
            ext_write_valid <= 1'b1;
            ext_write <= '{PR: {2'b11, k[1:0], fwd_bank}, data: fwd_data};
            fwd_pending = 1'b0;
        end else if (rand_below(4) == 0) begin
            ext_write_valid <= 1'b1;
            ext_write <= '{PR: 6'd48 + 6'(rand_below(16)), data: next_rand()};
        end else begin
            ext_write_valid <= 1'b0;
        end
        if (rand_below(4) == 0) begin
            ext_read_valid <= 1'b1;
            ext_read_PR    <= 6'(rand_below(64));
        end else begin
            ext_read_valid <= 1'b0;
        end
    endtask

    task automatic drive_cycle(input logic valid, input issue_op_t op);
        @(posedge CLK);
        issue_valid <= valid;
        issue       <= op;
        drive_ext();
    endtask

    task automatic build_op(input int n, output issue_op_t op, output logic [31:0] a_val,
                            output logic [31:0] b_val, output bit fwd,
                            output logic [1:0] fbank, output logic [31:0] fdata);
        int pick;
        op           = '0;
        op.op        = alu_op_t'(4'(rand_below(16)));
        op.A_is_zero = (rand_below(8) == 0);
        op.B_is_zero = (rand_below(8) == 0);
        // a zeroed operand may name any register
        op.A_PR      = 6'(rand_below(op.A_is_zero ? 64 : 32));
        op.B_PR      = 6'(rand_below(op.B_is_zero ? 64 : 32));
        op.dest_PR   = 6'd32 + 6'(rand_below(16));
        op.ROB_index = 6'(n);
        fdata        = next_rand();
        fbank        = 2'd0;
        fwd          = 1'b0;
        pick         = rand_below(6);
        if (pick == 0 && !op.A_is_zero) begin
            op.A_forward = 1'b1;
            fwd          = 1'b1;
            fbank        = op.A_PR[1:0];
        end else if (pick == 1 && !op.B_is_zero) begin
            op.B_forward = 1'b1;
            fwd          = 1'b1;
            fbank        = op.B_PR[1:0];
        end
        a_val = op.A_is_zero ? 32'h0 : (op.A_forward ? fdata : model_regs[op.A_PR]);
        b_val = op.B_is_zero ? 32'h0 : (op.B_forward ? fdata : model_regs[op.B_PR]);
    endtask

    // holds the issue until ready is seen before an edge
    task automatic wait_accept(input issue_op_t op);
        int cycles;
        cycles = 0;
        @(negedge CLK);
        while (!issue_ready && !timed_out) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("ERROR: timeout, ROB index %0d not accepted", op.ROB_index);
                other_errors++;
                timed_out = 1'b1;
            end else begin
                drive_cycle(1'b1, op);
                @(negedge CLK);
            end
        end
    endtask

    task automatic finish_run();
        int assert_errors;
        assert_errors = u_dut.u_pipeline.u_sva.fail_count;
        $display("checks %0d, value errors %0d, other errors %0d, assertion errors %0d",
                 checks, value_errors, other_errors, assert_errors);
        if (value_errors == 0 && other_errors == 0 && assert_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // --------------------------------------------------
    // monitor, mid-cycle when all signals are settled

    always @(negedge CLK) begin : monitor
        wb_req_t exp_wb;
        logic    exp_ready;
        if (nRST) begin
            if (ext_read_valid) begin
                checks++;
                if (ext_read_data !== model_regs[ext_read_PR]) begin
                    value_errors++;
                    $display("FAILED ext_read_data (PR %h): got %h expected %h",
                             ext_read_PR, ext_read_data, model_regs[ext_read_PR]);
                end
            end
            // the external write owns its bank for the cycle
            if (WB_valid) begin
                checks++;
                exp_ready = !(ext_write_valid && ext_write.PR[1:0] == wb.PR[1:0]);
                if (WB_ready !== exp_ready) begin
                    value_errors++;
                    $display("FAILED WB_ready: got %h expected %h", WB_ready, exp_ready);
                end
            end
            if (WB_valid && WB_ready) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("ERROR: writeback of ROB index %0d with nothing outstanding",
                             wb.ROB_index);
                end else begin
                    exp_wb = exp_q.pop_front();
                    checks++;
                    if (wb.data !== exp_wb.data) begin
                        value_errors++;
                        $display("FAILED wb.data: got %h expected %h", wb.data, exp_wb.data);
                    end
                    if (wb.PR !== exp_wb.PR) begin
                        value_errors++;
                        $display("FAILED wb.PR: got %h expected %h", wb.PR, exp_wb.PR);
                    end
                    if (wb.ROB_index !== exp_wb.ROB_index) begin
                        value_errors++;
                        $display("FAILED wb.ROB_index: got %h expected %h",
                                 wb.ROB_index, exp_wb.ROB_index);
                    end
                    model_regs[exp_wb.PR] = exp_wb.data;
                end
            end
            if (ext_write_valid) begin
                model_regs[ext_write.PR] = ext_write.data;
            end
        end
    end

    // --------------------------------------------------
    // main sequence

    initial begin : stimulus
        issue_op_t   op;
        logic [31:0] a_val;
        logic [31:0] b_val;
        bit          op_fwd;
        logic [1:0]  op_fbank;
        logic [31:0] op_fdata;
        int          gap;
        int          cycles;
        CLK             = 1'b0;
        nRST            = 1'b0;
        issue_valid     = 1'b0;
        issue           = '0;
        ext_write_valid = 1'b0;
        ext_write       = '0;
        ext_read_valid  = 1'b0;
        ext_read_PR     = '0;
        lcg_state       = 32'd22207;
        checks          = 0;
        value_errors    = 0;
        other_errors    = 0;
        timed_out       = 1'b0;
        fwd_pending     = 1'b0;
        for (int r = 0; r < PR_COUNT; r++) begin
            model_regs[r] = 32'h0;
        end

        repeat (10) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        if (WB_valid !== 1'b0) begin
            value_errors++;
            $display("FAILED WB_valid after reset: got %h expected %h", WB_valid, 1'b0);
        end
        if (issue_ready !== 1'b1) begin
            value_errors++;
            $display("FAILED issue_ready after reset: got %h expected %h", issue_ready, 1'b1);
        end

        // preload the source registers
        for (int r = 0; r < 32; r++) begin
            @(posedge CLK);
            ext_write_valid <= 1'b1;
            ext_write       <= '{PR: 6'(r), data: next_rand()};
        end
        @(posedge CLK);
        ext_write_valid <= 1'b0;

        for (int n = 0; n < NUM_OPS && !timed_out; n++) begin
            build_op(n, op, a_val, b_val, op_fwd, op_fbank, op_fdata);
            gap = (rand_below(4) == 0) ? rand_below(3) + 1 : 0;
            repeat (gap) drive_cycle(1'b0, op);
            drive_cycle(1'b1, op);
            wait_accept(op);
            if (!timed_out) begin
                exp_q.push_back('{data: ref_alu(op.op, a_val, b_val), PR: op.dest_PR,
                                  ROB_index: op.ROB_index});
                fwd_pending = op_fwd;
                fwd_bank    = op_fbank;
                fwd_data    = op_fdata;
            end
        end

        // drain, still with random external traffic
        cycles = 0;
        while (exp_q.size() != 0 && !timed_out) begin
            drive_cycle(1'b0, op);
            @(negedge CLK);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("ERROR: timeout, %0d writebacks never completed", exp_q.size());
                other_errors++;
                timed_out = 1'b1;
            end
        end

        // read back every register through the external port
        if (!timed_out) begin
            for (int r = 0; r < PR_COUNT; r++) begin
                @(posedge CLK);
                issue_valid     <= 1'b0;
                ext_write_valid <= 1'b0;
                ext_read_valid  <= 1'b1;
                ext_read_PR     <= 6'(r);
            end
            @(posedge CLK);
            ext_read_valid <= 1'b0;
            @(negedge CLK);
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- test/alu_lane_sva.sv
// concurrent checks bound into alu_reg_pipeline
// a pending read is derived from the OC state, since the flags live in the PRF
// checks are disabled while nRST is low
`timescale 1ns/1ps
`default_nettype none

module alu_lane_sva (
    input logic                      CLK,
    input logic                      nRST,
    input logic                      issue_ready,
    input logic                      WB_valid,
    input core_types_pkg::wb_req_t   wb,
    input logic                      WB_ready,
    input logic                      A_reg_read_ack,
    input logic                      B_reg_read_ack,
    input logic                      valid_oc,
    input core_types_pkg::issue_op_t op_oc,
    input logic                      A_saved_oc,
    input logic                      B_saved_oc
);

    int fail_count = 0;

    // writeback holds under back-pressure
    property wb_hold_p;
        @(posedge CLK) disable iff (!nRST)
        (WB_valid && !WB_ready) |=> (WB_valid && $stable(wb));
    endproperty
    assert property (wb_hold_p) else begin
        fail_count++;
        $error("wb not held while WB_ready low");
    end

    // an ack needs an operand that still waits for a register read
    property a_ack_pending_p;
        @(posedge CLK) disable iff (!nRST)
        A_reg_read_ack |-> (valid_oc && !op_oc.A_is_zero && !op_oc.A_forward && !A_saved_oc);
    endproperty
    assert property (a_ack_pending_p) else begin
        fail_count++;
        $error("A ack without pending read");
    end

    property b_ack_pending_p;
        @(posedge CLK) disable iff (!nRST)
        B_reg_read_ack |-> (valid_oc && !op_oc.B_is_zero && !op_oc.B_forward && !B_saved_oc);
    endproperty
    assert property (b_ack_pending_p) else begin
        fail_count++;
        $error("B ack without pending read");
    end

    // first cycle out of reset
    assert property (@(posedge CLK) $rose(nRST) |-> issue_ready) else begin
        fail_count++;
        $error("issue_ready low after reset");
    end

endmodule

`default_nettype wire

//--- src/alu_lane_top.sv
// ALU register-register lane with its register file slice
// WB_valid, wb and WB_ready are copies of the internal writeback, for observation
// READ_PORTS_PER_BANK of 1 or 2 are supported
`timescale 1ns/1ps
`default_nettype none

module alu_lane_top #(
    parameter int  READ_PORTS_PER_BANK = 2,
    localparam int PORT_W = (READ_PORTS_PER_BANK > 1) ? $clog2(READ_PORTS_PER_BANK) : 1
) (
    input  logic                       CLK,
    input  logic                       nRST,

    // issue port
    input  logic                       issue_valid,
    input  core_types_pkg::issue_op_t  issue,
    output logic                       issue_ready,

    // writeback, observed
    output logic                       WB_valid,
    output core_types_pkg::wb_req_t    wb,
    output logic                       WB_ready,

    // external ports
    input  logic                       ext_write_valid,
    input  core_types_pkg::ext_write_t ext_write,
    input  logic                       ext_read_valid,
    input  logic [core_types_pkg::LOG_PR_COUNT-1:0] ext_read_PR,
    output logic [31:0]                ext_read_data
);
    import core_types_pkg::*;

    logic                    A_reg_read_ack;
    logic [PORT_W-1:0]       A_reg_read_port;
    logic                    B_reg_read_ack;
    logic [PORT_W-1:0]       B_reg_read_port;
    logic [PRF_BANK_COUNT-1:0][READ_PORTS_PER_BANK-1:0][31:0] reg_read_data_by_bank_by_port;
    logic [PRF_BANK_COUNT-1:0][31:0] forward_data_by_bank;

    alu_reg_pipeline #(
        .READ_PORTS_PER_BANK (READ_PORTS_PER_BANK)
    ) u_pipeline (
        .CLK                           (CLK),
        .nRST                          (nRST),
        .issue_valid                   (issue_valid),
        .issue                         (issue),
        .issue_ready                   (issue_ready),
        .A_reg_read_ack                (A_reg_read_ack),
        .A_reg_read_port               (A_reg_read_port),
        .B_reg_read_ack                (B_reg_read_ack),
        .B_reg_read_port               (B_reg_read_port),
        .reg_read_data_by_bank_by_port (reg_read_data_by_bank_by_port),
        .forward_data_by_bank          (forward_data_by_bank),
        .WB_valid                      (WB_valid),
        .wb                            (wb),
        .WB_ready                      (WB_ready)
    );

    prf_banks #(
        .READ_PORTS_PER_BANK (READ_PORTS_PER_BANK)
    ) u_prf (
        .CLK                           (CLK),
        .nRST                          (nRST),
        .issue_valid                   (issue_valid),
        .issue_ready                   (issue_ready),
        .issue                         (issue),
        .A_reg_read_ack                (A_reg_read_ack),
        .A_reg_read_port               (A_reg_read_port),
        .B_reg_read_ack                (B_reg_read_ack),
        .B_reg_read_port               (B_reg_read_port),
        .reg_read_data_by_bank_by_port (reg_read_data_by_bank_by_port),
        .forward_data_by_bank          (forward_data_by_bank),
        .WB_valid                      (WB_valid),
        .wb                            (wb),
        .WB_ready                      (WB_ready),
        .ext_write_valid               (ext_write_valid),
        .ext_write                     (ext_write),
        .ext_read_valid                (ext_read_valid),
        .ext_read_PR                   (ext_read_PR),
        .ext_read_data                 (ext_read_data)
    );

endmodule

`default_nettype wire

//--- src/prf_banks.sv
// banked physical register file slice for the ALU lane
// one write per bank per cycle, the external write wins over writeback
// external read always gets port 0 of its bank, then A, then B
// reads see the array before this cycle's write; forward data covers the write
`timescale 1ns/1ps
`default_nettype none

module prf_banks #(
    parameter int  READ_PORTS_PER_BANK = 2,
    localparam int PORT_W = (READ_PORTS_PER_BANK > 1) ? $clog2(READ_PORTS_PER_BANK) : 1
) (
    input  logic                      CLK,
    input  logic                      nRST,

    // issue handshake, watched to record pending reads
    input  logic                      issue_valid,
    input  logic                      issue_ready,
    input  core_types_pkg::issue_op_t issue,

    // read grants and data to the pipeline
    output logic                      A_reg_read_ack,
    output logic [PORT_W-1:0]         A_reg_read_port,
    output logic                      B_reg_read_ack,
    output logic [PORT_W-1:0]         B_reg_read_port,
    output logic [core_types_pkg::PRF_BANK_COUNT-1:0][READ_PORTS_PER_BANK-1:0][31:0]
                                      reg_read_data_by_bank_by_port,
    output logic [core_types_pkg::PRF_BANK_COUNT-1:0][31:0]
                                      forward_data_by_bank,

    // writeback from the pipeline
    input  logic                      WB_valid,
    input  core_types_pkg::wb_req_t   wb,
    output logic                      WB_ready,

    // ports of the other pipelines
    input  logic                      ext_write_valid,
    input  core_types_pkg::ext_write_t ext_write,
    input  logic                      ext_read_valid,
    input  logic [core_types_pkg::LOG_PR_COUNT-1:0] ext_read_PR,
    output logic [31:0]               ext_read_data
);
    import core_types_pkg::*;

    localparam int REGS_PER_BANK = PR_COUNT / PRF_BANK_COUNT;
    localparam int ROW_W         = LOG_PR_COUNT - LOG_PRF_BANK_COUNT;

    logic [31:0] prf_array [PRF_BANK_COUNT][REGS_PER_BANK];

    logic [LOG_PRF_BANK_COUNT-1:0] ext_write_bank;
    logic [LOG_PRF_BANK_COUNT-1:0] wb_bank;
    logic [LOG_PRF_BANK_COUNT-1:0] ext_read_bank;
    logic [LOG_PRF_BANK_COUNT-1:0] A_bank;
    logic [LOG_PRF_BANK_COUNT-1:0] B_bank;
    logic                          wb_write;

    logic                          A_pending;
    logic                          B_pending;
    logic [LOG_PR_COUNT-1:0]       A_PR_q;
    logic [LOG_PR_COUNT-1:0]       B_PR_q;
    int                            A_used;
    int                            B_used;

    logic [PRF_BANK_COUNT-1:0][READ_PORTS_PER_BANK-1:0][ROW_W-1:0] read_row;

    assign ext_write_bank = ext_write.PR[LOG_PRF_BANK_COUNT-1:0];
    assign wb_bank        = wb.PR[LOG_PRF_BANK_COUNT-1:0];
    assign ext_read_bank  = ext_read_PR[LOG_PRF_BANK_COUNT-1:0];
    assign A_bank         = A_PR_q[LOG_PRF_BANK_COUNT-1:0];
    assign B_bank         = B_PR_q[LOG_PRF_BANK_COUNT-1:0];

    // --------------------------------------------------
    // write side

    assign WB_ready = ~(ext_write_valid & (ext_write_bank == wb_bank));
    assign wb_write = WB_valid & WB_ready;

    always_comb begin
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            forward_data_by_bank[b] = 32'h0;
            if (ext_write_valid && ext_write_bank == LOG_PRF_BANK_COUNT'(b)) begin
                forward_data_by_bank[b] = ext_write.data;
            end else if (wb_write && wb_bank == LOG_PRF_BANK_COUNT'(b)) begin
                forward_data_by_bank[b] = wb.data;
            end
        end
    end

    // both writes can land together only in different banks
    always_ff @(posedge CLK) begin
        if (!nRST) begin
            for (int b = 0; b < PRF_BANK_COUNT; b++) begin
                for (int r = 0; r < REGS_PER_BANK; r++) begin
                    prf_array[b][r] <= 32'h0;
                end
            end
        end else begin
            if (ext_write_valid) begin
                prf_array[ext_write_bank][ext_write.PR[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]]
                    <= ext_write.data;
            end
            if (wb_write) begin
                prf_array[wb_bank][wb.PR[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]] <= wb.data;
            end
        end
    end

    // --------------------------------------------------
    // pending reads of the operation in OC

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            A_pending <= 1'b0;
            B_pending <= 1'b0;
        end else if (issue_valid && issue_ready) begin
            A_pending <= ~(issue.A_forward | issue.A_is_zero);
            B_pending <= ~(issue.B_forward | issue.B_is_zero);
        end else begin
            A_pending <= A_pending & ~A_reg_read_ack;
            B_pending <= B_pending & ~B_reg_read_ack;
        end
    end

    always_ff @(posedge CLK) begin
        if (issue_valid && issue_ready) begin
            A_PR_q <= issue.A_PR;
            B_PR_q <= issue.B_PR;
        end
    end

    // port grant, counting ports already taken in the same bank
    always_comb begin
        A_used = (ext_read_valid && ext_read_bank == A_bank) ? 1 : 0;
        A_reg_read_ack  = A_pending && (A_used < READ_PORTS_PER_BANK);
        A_reg_read_port = PORT_W'(A_used);

        B_used = (ext_read_valid && ext_read_bank == B_bank) ? 1 : 0;
        if (A_reg_read_ack && A_bank == B_bank) begin
            B_used = B_used + 1;
        end
        B_reg_read_ack  = B_pending && (B_used < READ_PORTS_PER_BANK);
        B_reg_read_port = PORT_W'(B_used);
    end

    // --------------------------------------------------
    // read ports

    always_comb begin
        read_row = '0;
        if (ext_read_valid) begin
            read_row[ext_read_bank][0] = ext_read_PR[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
        end
        if (A_reg_read_ack) begin
            read_row[A_bank][A_reg_read_port] = A_PR_q[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
        end
        if (B_reg_read_ack) begin
            read_row[B_bank][B_reg_read_port] = B_PR_q[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
        end
    end

    always_comb begin
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            for (int p = 0; p < READ_PORTS_PER_BANK; p++) begin
                reg_read_data_by_bank_by_port[b][p] = prf_array[b][read_row[b][p]];
            end
        end
    end

    assign ext_read_data = reg_read_data_by_bank_by_port[ext_read_bank][0];

endmodule

`default_nettype wire

//--- src/alu_reg_pipeline.sv
// two-stage register-register ALU lane: operand collect (OC) then writeback (WB)
// one operation per stage; operands that arrive while OC waits are saved
// forward data is only valid in the first OC cycle of an operation
// the issuer guarantees a write to the forwarded bank in that cycle
`timescale 1ns/1ps
`default_nettype none

module alu_reg_pipeline #(
    parameter int  READ_PORTS_PER_BANK = 2,
    localparam int PORT_W = (READ_PORTS_PER_BANK > 1) ? $clog2(READ_PORTS_PER_BANK) : 1
) (
    input  logic                      CLK,
    input  logic                      nRST,

    // issue from the issue queue
    input  logic                      issue_valid,
    input  core_types_pkg::issue_op_t issue,
    output logic                      issue_ready,

    // read grants and data from the register file
    input  logic                      A_reg_read_ack,
    input  logic [PORT_W-1:0]         A_reg_read_port,
    input  logic                      B_reg_read_ack,
    input  logic [PORT_W-1:0]         B_reg_read_port,
    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][READ_PORTS_PER_BANK-1:0][31:0]
                                      reg_read_data_by_bank_by_port,
    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][31:0]
                                      forward_data_by_bank,

    // writeback to the register file
    output logic                      WB_valid,
    output core_types_pkg::wb_req_t   wb,
    input  logic                      WB_ready
);
    import core_types_pkg::*;

    logic stall_wb;
    logic launch_oc;

    // --------------------------------------------------
    // OC stage state
    logic                          valid_oc;
    issue_op_t                     op_oc;
    logic                          A_saved_oc;
    logic                          B_saved_oc;
    logic [31:0]                   A_saved_data_oc;
    logic [31:0]                   B_saved_data_oc;
    logic [LOG_PRF_BANK_COUNT-1:0] A_bank_oc;
    logic [LOG_PRF_BANK_COUNT-1:0] B_bank_oc;
    logic                          A_present_oc;
    logic                          B_present_oc;
    logic [31:0]                   A_next;
    logic [31:0]                   B_next;

    // WB stage state
    alu_op_t                       op_wb;
    logic [31:0]                   A_wb;
    logic [31:0]                   B_wb;
    logic [LOG_PR_COUNT-1:0]       PR_wb;
    logic [LOG_ROB_ENTRIES-1:0]    ROB_index_wb;
    logic [31:0]                   alu_out;

    // --------------------------------------------------
    // control

    assign stall_wb = WB_valid & ~WB_ready;

    assign A_bank_oc = op_oc.A_PR[LOG_PRF_BANK_COUNT-1:0];
    assign B_bank_oc = op_oc.B_PR[LOG_PRF_BANK_COUNT-1:0];

    // an operand is here if zero, saved, forwarded now, or granted now
    assign A_present_oc = op_oc.A_is_zero | A_saved_oc | op_oc.A_forward | A_reg_read_ack;
    assign B_present_oc = op_oc.B_is_zero | B_saved_oc | op_oc.B_forward | B_reg_read_ack;

    assign launch_oc   = valid_oc & ~stall_wb & A_present_oc & B_present_oc;
    assign issue_ready = ~valid_oc | launch_oc;

    // --------------------------------------------------
    // OC stage

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            valid_oc   <= 1'b0;
            op_oc      <= '0;
            A_saved_oc <= 1'b0;
            B_saved_oc <= 1'b0;
        end else if (issue_ready) begin
            valid_oc   <= issue_valid;
            op_oc      <= issue;
            A_saved_oc <= 1'b0;
            B_saved_oc <= 1'b0;
        end else begin
            // waiting: whatever came in this cycle is now in the saved regs
            A_saved_oc      <= A_saved_oc | op_oc.A_forward | A_reg_read_ack;
            B_saved_oc      <= B_saved_oc | op_oc.B_forward | B_reg_read_ack;
            op_oc.A_forward <= 1'b0;
            op_oc.B_forward <= 1'b0;
        end
    end

    // priority zero, saved, forward, read port
    always_comb begin
        if (op_oc.A_is_zero) begin
            A_next = 32'h0;
        end else if (A_saved_oc) begin
            A_next = A_saved_data_oc;
        end else if (op_oc.A_forward) begin
            A_next = forward_data_by_bank[A_bank_oc];
        end else begin
            A_next = reg_read_data_by_bank_by_port[A_bank_oc][A_reg_read_port];
        end

        if (op_oc.B_is_zero) begin
            B_next = 32'h0;
        end else if (B_saved_oc) begin
            B_next = B_saved_data_oc;
        end else if (op_oc.B_forward) begin
            B_next = forward_data_by_bank[B_bank_oc];
        end else begin
            B_next = reg_read_data_by_bank_by_port[B_bank_oc][B_reg_read_port];
        end
    end

    // saved values recirculate through A_next/B_next once the flag is set
    always_ff @(posedge CLK) begin
        A_saved_data_oc <= A_next;
        B_saved_data_oc <= B_next;
    end

    // --------------------------------------------------
    // WB stage

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            WB_valid <= 1'b0;
        end else if (!stall_wb) begin
            WB_valid <= launch_oc;
        end
    end

    always_ff @(posedge CLK) begin
        if (!stall_wb) begin
            op_wb        <= op_oc.op;
            A_wb         <= A_next;
            B_wb         <= B_next;
            PR_wb        <= op_oc.dest_PR;
            ROB_index_wb <= op_oc.ROB_index;
        end
    end

    alu u_alu (
        .op  (op_wb),
        .A   (A_wb),
        .B   (B_wb),
        .out (alu_out)
    );

    assign wb = '{data: alu_out, PR: PR_wb, ROB_index: ROB_index_wb};

endmodule

`default_nettype wire

//--- src/alu.sv
// combinational RV32 integer ALU
// shift amounts come from B[4:0], undefined op codes return zero
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  core_types_pkg::alu_op_t op,
    input  logic [31:0]             A,
    input  logic [31:0]             B,
    output logic [31:0]             out
);
    import core_types_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = B[4:0];
    assign lt_signed   = $signed(A) < $signed(B);
    assign lt_unsigned = A < B;

    always_comb begin
        case (op)
            ALU_ADD: begin
                out = A + B;
            end
            ALU_SUB: begin
                out = A - B;
            end
            ALU_SLL: begin
                out = A << shamt;
            end
            ALU_SLT: begin
                out = {31'h0, lt_signed};
            end
            ALU_SLTU: begin
                out = {31'h0, lt_unsigned};
            end
            ALU_XOR: begin
                out = A ^ B;
            end
            ALU_SRL: begin
                out = A >> shamt;
            end
            // arithmetic shift keeps the sign of A
            ALU_SRA: begin
                out = $unsigned($signed(A) >>> shamt);
            end
            ALU_OR: begin
                out = A | B;
            end
            ALU_AND: begin
                out = A & B;
            end
            default: begin
                out = 32'h0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/core_types_pkg.sv
// shared sizes, ALU op codes and the structs that travel between the
// issue port, the ALU pipeline and the banked register file
// the bank of a physical register is its low LOG_PRF_BANK_COUNT bits
`default_nettype none

package core_types_pkg;

    localparam int PRF_BANK_COUNT     = 4;
    localparam int LOG_PRF_BANK_COUNT = 2;
    localparam int PR_COUNT           = 64;
    localparam int LOG_PR_COUNT       = 6;
    localparam int LOG_ROB_ENTRIES    = 6;

    // RV32 register-register ops, codes 10 to 15 give zero
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_t;

    // operation as sent by the issue queue
    typedef struct packed {
        alu_op_t                     op;
        logic [LOG_PR_COUNT-1:0]     A_PR;
        logic                        A_forward;
        logic                        A_is_zero;
        logic [LOG_PR_COUNT-1:0]     B_PR;
        logic                        B_forward;
        logic                        B_is_zero;
        logic [LOG_PR_COUNT-1:0]     dest_PR;
        logic [LOG_ROB_ENTRIES-1:0]  ROB_index;
    } issue_op_t;

    typedef struct packed {
        logic [31:0]                 data;
        logic [LOG_PR_COUNT-1:0]     PR;
        logic [LOG_ROB_ENTRIES-1:0]  ROB_index;
    } wb_req_t;

    typedef struct packed {
        logic [LOG_PR_COUNT-1:0]     PR;
        logic [31:0]                 data;
    } ext_write_t;

endpackage

`default_nettype wire
